//--- logic/bus_pkg.sv
package bus_pkg;

  // core side widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // the lane logic is written for a 64-bit bus only
  localparam int AXI_DATA_W = 64;

  // mtime halves, answered by the local timer
  localparam logic [ADDR_W-1:0] RTC_ADDR    = 32'h0200_BFF8;
  localparam logic [ADDR_W-1:0] RTC_ADDR_UP = 32'h0200_BFFC;

  typedef enum logic [2:0] {
    IF_ADDR  = 3'd0,  // idle, fetch may issue ar
    IF_DATA  = 3'd1,  // waiting on fetch r beat
    LS_ADDR  = 3'd2,  // load/store address phase
    LS_READ  = 3'd3,  // waiting on load r beat
    LS_WRITE = 3'd4,  // waiting on b
    LS_TIMER = 3'd5   // local mtime read
  } arb_state_e;

  // AXI AxSIZE codes
  typedef enum logic [2:0] {
    SIZE_B = 3'b000,
    SIZE_H = 3'b001,
    SIZE_W = 3'b010
  } axi_size_e;

endpackage

//--- logic/lane_align.sv
`timescale 1ns/1ps

module lane_align #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic [ADDR_W-1:0]                 sel_addr_i,
  input  logic [DATA_W/8-1:0]               sel_strb_i,
  input  logic                              sel_write_i,
  input  logic [DATA_W-1:0]                 w_data_i,
  output logic [ADDR_W-1:0]                 ar_addr_o,
  output bus_pkg::axi_size_e                ar_size_o,
  output logic [ADDR_W-1:0]                 aw_addr_o,
  output bus_pkg::axi_size_e                aw_size_o,
  output logic [bus_pkg::AXI_DATA_W-1:0]    w_data_o,
  output logic [bus_pkg::AXI_DATA_W/8-1:0]  w_strb_o,
  input  logic [bus_pkg::AXI_DATA_W-1:0]    r_data_i,
  output logic [DATA_W-1:0]                 lane_rdata_o
);

  bus_pkg::axi_size_e size;
  logic [DATA_W-1:0]  wdata_shift;
  logic [3:0]         strb_shift;

  // transfer size from the byte strobes
  always_comb
  begin
    if (sel_strb_i == 'h1)
    begin
      size = bus_pkg::SIZE_B;
    end
    else if (sel_strb_i == 'h3)
    begin
      size = bus_pkg::SIZE_H;
    end
    else
    begin
      size = bus_pkg::SIZE_W; // 0xF and fetches
    end
  end

  assign ar_addr_o = sel_addr_i;
  assign aw_addr_o = sel_addr_i;
  assign ar_size_o = size;
  assign aw_size_o = size;

  // byte offset inside the word
  assign wdata_shift = w_data_i << {sel_addr_i[1:0], 3'b000};
  assign strb_shift  = sel_strb_i[3:0] << sel_addr_i[1:0];

  assign w_data_o = {wdata_shift, wdata_shift}; // both halves, strobe picks one

  always_comb
  begin
    if (!sel_write_i)
    begin
      w_strb_o = '0;
    end
    else if (sel_addr_i[2])
    begin
      w_strb_o = {strb_shift, 4'b0000};
    end
    else
    begin
      w_strb_o = {4'b0000, strb_shift};
    end
  end

  // word lane from addr bit 2
  assign lane_rdata_o = sel_addr_i[2] ? r_data_i[63:32] : r_data_i[31:0];

endmodule

//--- logic/clint_timer.sv
`timescale 1ns/1ps

module clint_timer #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              rd_i,
  input  logic [ADDR_W-1:0] addr_i,
  output logic [DATA_W-1:0] rdata_o,
  output logic              rvalid_o
);

  logic [63:0] mtime;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime    <= '0;
      rvalid_o <= 1'b0;
    end
    else
    begin
      mtime    <= mtime + 64'd1;
      rvalid_o <= rd_i;
    end
  end

  // read data only moves on a read
  always_ff @(posedge clk)
  begin
    if (rd_i)
    begin
      if (addr_i == bus_pkg::RTC_ADDR_UP)
      begin
        rdata_o <= mtime[63:32];
      end
      else
      begin
        rdata_o <= mtime[31:0];
      end
    end
  end

endmodule

//--- logic/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic                clk,
  input  logic                rst,

  // fetch
  input  logic [ADDR_W-1:0]   ifu_araddr_i,
  input  logic                ifu_arvalid_i,
  output logic [DATA_W-1:0]   ifu_rdata_o,
  output logic                ifu_rvalid_o,

  // load
  input  logic [ADDR_W-1:0]   lsu_araddr_i,
  input  logic                lsu_arvalid_i,
  input  logic [DATA_W/8-1:0] lsu_rstrb_i,
  output logic [DATA_W-1:0]   lsu_rdata_o,
  output logic                lsu_rvalid_o,

  // store
  input  logic [ADDR_W-1:0]   lsu_awaddr_i,
  input  logic                lsu_awvalid_i,
  input  logic [DATA_W/8-1:0] lsu_wstrb_i,
  output logic                lsu_wready_o,

  // AXI handshakes
  output logic                ar_valid_o,
  input  logic                ar_ready_i,
  input  logic                r_valid_i,
  output logic                r_ready_o,
  output logic                aw_valid_o,
  input  logic                aw_ready_i,
  output logic                w_valid_o,
  input  logic                w_ready_i,
  input  logic                b_valid_i,
  output logic                b_ready_o,

  // aligner
  output logic [ADDR_W-1:0]   sel_addr_o,
  output logic [DATA_W/8-1:0] sel_strb_o,
  output logic                sel_write_o,
  input  logic [DATA_W-1:0]   lane_rdata_i,

  // timer
  output logic                timer_rd_o,
  input  logic [DATA_W-1:0]   timer_rdata_i,
  input  logic                timer_rvalid_i
);

  bus_pkg::arb_state_e state_q;
  bus_pkg::arb_state_e state_d;

  logic ls_req;
  logic ls_write;
  logic ls_phase;
  logic is_timer;
  logic if_grant;
  logic if_ar_hold;
  logic ar_fire;
  logic aw_fire;
  logic w_fire;
  logic aw_done;
  logic w_done;

  assign ls_req   = lsu_arvalid_i | lsu_awvalid_i;
  assign ls_write = lsu_awvalid_i & ~lsu_arvalid_i; // load wins if both
  assign is_timer = lsu_arvalid_i &
                    ((lsu_araddr_i == bus_pkg::RTC_ADDR) |
                     (lsu_araddr_i == bus_pkg::RTC_ADDR_UP));

  assign ls_phase = (state_q != bus_pkg::IF_ADDR) & (state_q != bus_pkg::IF_DATA);

  // a fetch ar already on the bus keeps its slot until accepted
  assign if_grant = (state_q == bus_pkg::IF_ADDR) & ifu_arvalid_i & (if_ar_hold | ~ls_req);

  assign ar_valid_o = if_grant |
                      ((state_q == bus_pkg::LS_ADDR) & lsu_arvalid_i & ~is_timer);
  assign aw_valid_o = (state_q == bus_pkg::LS_ADDR) & ls_write & ~aw_done;
  assign w_valid_o  = (state_q == bus_pkg::LS_ADDR) & ls_write & ~w_done;
  assign r_ready_o  = 1'b1;
  assign b_ready_o  = 1'b1;

  assign ar_fire = ar_valid_o & ar_ready_i;
  assign aw_fire = aw_valid_o & aw_ready_i;
  assign w_fire  = w_valid_o & w_ready_i;

  assign timer_rd_o = (state_q == bus_pkg::LS_ADDR) & is_timer;

  // requester side of the address and strobe
  assign sel_addr_o  = !ls_phase ? ifu_araddr_i :
                       ls_write  ? lsu_awaddr_i : lsu_araddr_i;
  assign sel_strb_o  = !ls_phase ? '1 :
                       ls_write  ? lsu_wstrb_i : lsu_rstrb_i;
  assign sel_write_o = ls_phase & ls_write;

  // returned data goes to the granted requester only
  assign ifu_rdata_o  = lane_rdata_i;
  assign ifu_rvalid_o = (state_q == bus_pkg::IF_DATA) & r_valid_i;
  assign lsu_rdata_o  = (state_q == bus_pkg::LS_TIMER) ? timer_rdata_i : lane_rdata_i;
  assign lsu_rvalid_o = ((state_q == bus_pkg::LS_READ) & r_valid_i) |
                        ((state_q == bus_pkg::LS_TIMER) & timer_rvalid_i);
  assign lsu_wready_o = (state_q == bus_pkg::LS_WRITE) & b_valid_i;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      bus_pkg::IF_ADDR:
      begin
        if (if_grant)
        begin
          if (ar_ready_i)
          begin
            state_d = bus_pkg::IF_DATA;
          end
        end
        else if (ls_req)
        begin
          state_d = bus_pkg::LS_ADDR;
        end
      end
      bus_pkg::IF_DATA:
      begin
        if (r_valid_i)
        begin
          state_d = bus_pkg::IF_ADDR;
        end
      end
      bus_pkg::LS_ADDR:
      begin
        if (ls_write)
        begin
          // aw and w may finish in either order
          if ((aw_done | aw_fire) & (w_done | w_fire))
          begin
            state_d = bus_pkg::LS_WRITE;
          end
        end
        else if (is_timer)
        begin
          state_d = bus_pkg::LS_TIMER;
        end
        else if (ar_fire)
        begin
          state_d = bus_pkg::LS_READ;
        end
        else if (!ls_req)
        begin
          state_d = bus_pkg::IF_ADDR; // request withdrawn
        end
      end
      bus_pkg::LS_READ:
      begin
        if (r_valid_i)
        begin
          state_d = bus_pkg::IF_ADDR;
        end
      end
      bus_pkg::LS_WRITE:
      begin
        if (b_valid_i)
        begin
          state_d = bus_pkg::IF_ADDR;
        end
      end
      bus_pkg::LS_TIMER:
      begin
        if (timer_rvalid_i)
        begin
          state_d = bus_pkg::IF_ADDR;
        end
      end
      default:
      begin
        state_d = bus_pkg::IF_ADDR;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q    <= bus_pkg::IF_ADDR;
      if_ar_hold <= 1'b0;
      aw_done    <= 1'b0;
      w_done     <= 1'b0;
    end
    else
    begin
      state_q    <= state_d;
      if_ar_hold <= if_grant & ~ar_ready_i;
      aw_done    <= (state_d == bus_pkg::LS_ADDR) & (aw_done | aw_fire);
      w_done     <= (state_d == bus_pkg::LS_ADDR) & (w_done | w_fire);
    end
  end

endmodule

//--- logic/mem_bus_top.sv
`timescale 1ns/1ps

module mem_bus_top #(
  parameter int ADDR_W = bus_pkg::ADDR_W,
  parameter int DATA_W = bus_pkg::DATA_W
) (
  input  logic                               clk,
  input  logic                               rst,

  input  logic [ADDR_W-1:0]                  ifu_araddr_i,
  input  logic                               ifu_arvalid_i,
  output logic [DATA_W-1:0]                  ifu_rdata_o,
  output logic                               ifu_rvalid_o,

  input  logic [ADDR_W-1:0]                  lsu_araddr_i,
  input  logic                               lsu_arvalid_i,
  input  logic [DATA_W/8-1:0]                lsu_rstrb_i,
  output logic [DATA_W-1:0]                  lsu_rdata_o,
  output logic                               lsu_rvalid_o,

  input  logic [ADDR_W-1:0]                  lsu_awaddr_i,
  input  logic                               lsu_awvalid_i,
  input  logic [DATA_W-1:0]                  lsu_wdata_i,
  input  logic [DATA_W/8-1:0]                lsu_wstrb_i,
  output logic                               lsu_wready_o,

  output logic [ADDR_W-1:0]                  axi_araddr_o,
  output logic [2:0]                         axi_arsize_o,
  output logic [7:0]                         axi_arlen_o,
  output logic [1:0]                         axi_arburst_o,
  output logic [3:0]                         axi_arid_o,
  output logic                               axi_arvalid_o,
  input  logic                               axi_arready_i,

  input  logic [bus_pkg::AXI_DATA_W-1:0]     axi_rdata_i,
  input  logic                               axi_rvalid_i,
  output logic                               axi_rready_o,

  output logic [ADDR_W-1:0]                  axi_awaddr_o,
  output logic [2:0]                         axi_awsize_o,
  output logic [7:0]                         axi_awlen_o,
  output logic [1:0]                         axi_awburst_o,
  output logic [3:0]                         axi_awid_o,
  output logic                               axi_awvalid_o,
  input  logic                               axi_awready_i,

  output logic [bus_pkg::AXI_DATA_W-1:0]     axi_wdata_o,
  output logic [bus_pkg::AXI_DATA_W/8-1:0]   axi_wstrb_o,
  output logic                               axi_wlast_o,
  output logic                               axi_wvalid_o,
  input  logic                               axi_wready_i,

  input  logic                               axi_bvalid_i,
  output logic                               axi_bready_o
);

  logic [ADDR_W-1:0]   sel_addr;
  logic [DATA_W/8-1:0] sel_strb;
  logic                sel_write;
  logic [DATA_W-1:0]   lane_rdata;
  logic                timer_rd;
  logic [DATA_W-1:0]   timer_rdata;
  logic                timer_rvalid;

  // single beats, INCR, id 0
  assign axi_arlen_o   = 8'd0;
  assign axi_arburst_o = 2'b01;
  assign axi_arid_o    = 4'd0;
  assign axi_awlen_o   = 8'd0;
  assign axi_awburst_o = 2'b01;
  assign axi_awid_o    = 4'd0;
  assign axi_wlast_o   = axi_wvalid_o;

  bus_arbiter #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) u_arbiter (
    .clk            (clk),
    .rst            (rst),
    .ifu_araddr_i   (ifu_araddr_i),
    .ifu_arvalid_i  (ifu_arvalid_i),
    .ifu_rdata_o    (ifu_rdata_o),
    .ifu_rvalid_o   (ifu_rvalid_o),
    .lsu_araddr_i   (lsu_araddr_i),
    .lsu_arvalid_i  (lsu_arvalid_i),
    .lsu_rstrb_i    (lsu_rstrb_i),
    .lsu_rdata_o    (lsu_rdata_o),
    .lsu_rvalid_o   (lsu_rvalid_o),
    .lsu_awaddr_i   (lsu_awaddr_i),
    .lsu_awvalid_i  (lsu_awvalid_i),
    .lsu_wstrb_i    (lsu_wstrb_i),
    .lsu_wready_o   (lsu_wready_o),
    .ar_valid_o     (axi_arvalid_o),
    .ar_ready_i     (axi_arready_i),
    .r_valid_i      (axi_rvalid_i),
    .r_ready_o      (axi_rready_o),
    .aw_valid_o     (axi_awvalid_o),
    .aw_ready_i     (axi_awready_i),
    .w_valid_o      (axi_wvalid_o),
    .w_ready_i      (axi_wready_i),
    .b_valid_i      (axi_bvalid_i),
    .b_ready_o      (axi_bready_o),
    .sel_addr_o     (sel_addr),
    .sel_strb_o     (sel_strb),
    .sel_write_o    (sel_write),
    .lane_rdata_i   (lane_rdata),
    .timer_rd_o     (timer_rd),
    .timer_rdata_i  (timer_rdata),
    .timer_rvalid_i (timer_rvalid)
  );

  lane_align #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) u_align (
    .sel_addr_i   (sel_addr),
    .sel_strb_i   (sel_strb),
    .sel_write_i  (sel_write),
    .w_data_i     (lsu_wdata_i),
    .ar_addr_o    (axi_araddr_o),
    .ar_size_o    (axi_arsize_o),
    .aw_addr_o    (axi_awaddr_o),
    .aw_size_o    (axi_awsize_o),
    .w_data_o     (axi_wdata_o),
    .w_strb_o     (axi_wstrb_o),
    .r_data_i     (axi_rdata_i),
    .lane_rdata_o (lane_rdata)
  );

  clint_timer #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) u_timer (
    .clk      (clk),
    .rst      (rst),
    .rd_i     (timer_rd),
    .addr_i   (sel_addr),
    .rdata_o  (timer_rdata),
    .rvalid_o (timer_rvalid)
  );

endmodule

//--- tb/axi_mem_slave.sv
`timescale 1ns/1ps

module axi_mem_slave #(
  parameter int SEED = 16575
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] araddr_i,
  input  logic        arvalid_i,
  output logic        arready_o,
  output logic [63:0] rdata_o,
  output logic        rvalid_o,
  input  logic [31:0] awaddr_i,
  input  logic        awvalid_i,
  output logic        awready_o,
  input  logic [63:0] wdata_i,
  input  logic [7:0]  wstrb_i,
  input  logic        wvalid_i,
  output logic        wready_o,
  output logic        bvalid_o
);

  logic [7:0]  mem [0:4095]; // 4 KB, low 12 address bits
  integer      seed;
  logic [31:0] rnd;
  logic        r_pend;
  logic [1:0]  r_wait;
  logic [11:0] r_addr;
  logic        aw_got;
  logic        w_got;
  logic [11:0] w_addr;
  logic [63:0] w_data;
  logic [7:0]  w_strb;
  integer      k;

  initial
  begin
    seed = SEED;
    for (k = 0; k < 4096; k = k + 1)
    begin
      mem[k] = 8'(k ^ (k >> 5) ^ 8'h5a); // same fill as the tb mirror
    end
  end

  always @(posedge clk)
  begin
    if (rst)
    begin
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
      rdata_o   <= '0;
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      r_pend    <= 1'b0;
      aw_got    <= 1'b0;
      w_got     <= 1'b0;
    end
    else
    begin
      rnd = $random(seed);
      arready_o <= rnd[0];
      awready_o <= rnd[1];
      wready_o  <= rnd[4];
      rvalid_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      if (arvalid_i && arready_o)
      begin
        r_pend <= 1'b1;
        r_wait <= rnd[3:2];
        r_addr <= araddr_i[11:0];
      end
      if (r_pend)
      begin
        if (r_wait == 2'd0)
        begin
          rvalid_o <= 1'b1;
          r_pend   <= 1'b0;
          for (k = 0; k < 8; k = k + 1)
          begin
            rdata_o[8*k +: 8] <= mem[{r_addr[11:3], 3'(k)}];
          end
        end
        else
        begin
          r_wait <= r_wait - 2'd1;
        end
      end
      if (awvalid_i && awready_o)
      begin
        aw_got <= 1'b1;
        w_addr <= awaddr_i[11:0];
      end
      if (wvalid_i && wready_o)
      begin
        w_got  <= 1'b1;
        w_data <= wdata_i;
        w_strb <= wstrb_i;
      end
      if (aw_got && w_got)
      begin
        for (k = 0; k < 8; k = k + 1)
        begin
          if (w_strb[k])
          begin
            mem[{w_addr[11:3], 3'(k)}] = w_data[8*k +: 8];
          end
        end
        bvalid_o <= 1'b1;
        aw_got   <= 1'b0;
        w_got    <= 1'b0;
      end
    end
  end

endmodule

//--- tb/bus_assert.sv
`timescale 1ns/1ps

module bus_assert (
  input logic        clk,
  input logic        rst,
  input logic        arvalid,
  input logic        arready,
  input logic [31:0] araddr,
  input logic        awvalid,
  input logic        awready,
  input logic        wvalid,
  input logic        wready,
  input logic        rready,
  input logic        bready
);

  int fail_cnt = 0; // failed assertion count

  ar_hold: assert property (@(posedge clk) disable iff (rst) arvalid && !arready |=> arvalid)
    else
    begin
      $error("arvalid dropped before arready");
      fail_cnt = fail_cnt + 1;
    end
  aw_hold: assert property (@(posedge clk) disable iff (rst) awvalid && !awready |=> awvalid)
    else
    begin
      $error("awvalid dropped before awready");
      fail_cnt = fail_cnt + 1;
    end
  w_hold: assert property (@(posedge clk) disable iff (rst) wvalid && !wready |=> wvalid)
    else
    begin
      $error("wvalid dropped before wready");
      fail_cnt = fail_cnt + 1;
    end
  rb_ready: assert property (@(posedge clk) disable iff (rst) rready && bready)
    else
    begin
      $error("rready or bready low outside reset");
      fail_cnt = fail_cnt + 1;
    end
  no_timer_ar: assert property (@(posedge clk) disable iff (rst)
    arvalid |-> (araddr != bus_pkg::RTC_ADDR) && (araddr != bus_pkg::RTC_ADDR_UP))
    else
    begin
      $error("ar issued for an mtime address");
      fail_cnt = fail_cnt + 1;
    end

endmodule

bind mem_bus_top bus_assert u_assert (
  .clk     (clk),
  .rst     (rst),
  .arvalid (axi_arvalid_o),
  .arready (axi_arready_i),
  .araddr  (axi_araddr_o),
  .awvalid (axi_awvalid_o),
  .awready (axi_awready_i),
  .wvalid  (axi_wvalid_o),
  .wready  (axi_wready_i),
  .rready  (axi_rready_o),
  .bready  (axi_bready_o)
);

//--- tb/tb_mem_bus.sv
`timescale 1ns/1ps

module tb_mem_bus;

  localparam int N_FETCH = 20;
  localparam int N_STORE = 24; // 3 sizes x 8 offsets
  localparam int N_TIMER = 4;
  localparam int N_PAIR  = 8;
  localparam int N_TXN   = N_FETCH + 2 * N_STORE + N_TIMER + 2 * N_PAIR;
  localparam int LIMIT   = N_TXN * 40 + 8;
  localparam logic [1:0] BURST_INCR = 2'b01;

  logic clk, rst;
  logic [31:0] ifu_araddr, lsu_araddr, lsu_awaddr, lsu_wdata;
  logic ifu_arvalid, lsu_arvalid, lsu_awvalid;
  logic [3:0] lsu_rstrb, lsu_wstrb;
  logic [31:0] ifu_rdata_o, lsu_rdata_o;
  logic ifu_rvalid_o, lsu_rvalid_o, lsu_wready_o;
  logic [31:0] araddr, awaddr;
  logic [2:0] arsize, awsize;
  logic [7:0] arlen, awlen;
  logic [1:0] arburst, awburst;
  logic [3:0] arid, awid;
  logic arvalid, arready, rvalid, rready, awvalid, awready;
  logic wlast, wvalid, wready, bvalid, bready;
  logic [63:0] rdata, wdata;
  logic [7:0] wstrb;

  logic [7:0] ref_mem [0:4095];
  logic [63:0] cyc_since_rst;
  integer cyc;
  integer seed;
  integer err_cnt;
  logic ls_done;
  logic [31:0] st_addr [0:N_STORE-1];
  logic [3:0] st_strb [0:N_STORE-1];

  always #20 clk = ~clk;

  mem_bus_top #(.ADDR_W(bus_pkg::ADDR_W), .DATA_W(bus_pkg::DATA_W)) u_dut (
    .clk(clk), .rst(rst),
    .ifu_araddr_i(ifu_araddr), .ifu_arvalid_i(ifu_arvalid),
    .ifu_rdata_o(ifu_rdata_o), .ifu_rvalid_o(ifu_rvalid_o),
    .lsu_araddr_i(lsu_araddr), .lsu_arvalid_i(lsu_arvalid), .lsu_rstrb_i(lsu_rstrb),
    .lsu_rdata_o(lsu_rdata_o), .lsu_rvalid_o(lsu_rvalid_o),
    .lsu_awaddr_i(lsu_awaddr), .lsu_awvalid_i(lsu_awvalid), .lsu_wdata_i(lsu_wdata),
    .lsu_wstrb_i(lsu_wstrb), .lsu_wready_o(lsu_wready_o),
    .axi_araddr_o(araddr), .axi_arsize_o(arsize), .axi_arlen_o(arlen),
    .axi_arburst_o(arburst), .axi_arid_o(arid), .axi_arvalid_o(arvalid),
    .axi_arready_i(arready), .axi_rdata_i(rdata), .axi_rvalid_i(rvalid),
    .axi_rready_o(rready), .axi_awaddr_o(awaddr), .axi_awsize_o(awsize),
    .axi_awlen_o(awlen), .axi_awburst_o(awburst), .axi_awid_o(awid),
    .axi_awvalid_o(awvalid), .axi_awready_i(awready), .axi_wdata_o(wdata),
    .axi_wstrb_o(wstrb), .axi_wlast_o(wlast), .axi_wvalid_o(wvalid),
    .axi_wready_i(wready), .axi_bvalid_i(bvalid), .axi_bready_o(bready)
  );

  axi_mem_slave #(.SEED(16575)) u_mem (
    .clk(clk), .rst(rst),
    .araddr_i(araddr), .arvalid_i(arvalid), .arready_o(arready),
    .rdata_o(rdata), .rvalid_o(rvalid),
    .awaddr_i(awaddr), .awvalid_i(awvalid), .awready_o(awready),
    .wdata_i(wdata), .wstrb_i(wstrb), .wvalid_i(wvalid), .wready_o(wready),
    .bvalid_o(bvalid)
  );

  // word at the 4-byte aligned address
  function automatic logic [31:0] ref_read(input logic [31:0] addr);
    logic [11:0] b;
    b = {addr[11:2], 2'b00};
    return {ref_mem[b + 12'd3], ref_mem[b + 12'd2], ref_mem[b + 12'd1], ref_mem[b]};
  endfunction

  function automatic void update_mirror(input logic [31:0] addr, input logic [31:0] data,
                                        input logic [3:0] strb);
    logic [31:0] sdata;
    logic [3:0]  sstrb;
    sdata = data << {addr[1:0], 3'b000};
    sstrb = strb << addr[1:0]; // bits shifted past lane 3 are lost
    for (int i = 0; i < 4; i++)
    begin
      if (sstrb[i])
      begin
        ref_mem[{addr[11:2], 2'(i)}] = sdata[8*i +: 8];
      end
    end
  endfunction

  function automatic logic [2:0] size_of(input logic [3:0] strb);
    case (strb)
      4'h1: return 3'b000;
      4'h3: return 3'b001;
      default: return 3'b010;
    endcase
  endfunction

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      err_cnt = err_cnt + 1;
      $display("Error: time %0t signal %s got %h expected %h", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic fetch_and_compare(input logic [31:0] addr, input logic after_ls);
    @(posedge clk);
    ifu_araddr  <= addr;
    ifu_arvalid <= 1'b1;
    do
    begin
      @(negedge clk);
      if (arvalid && (!after_ls || ls_done))
      begin
        check_val("axi_araddr_o", araddr, addr);
      end
    end
    while (!ifu_rvalid_o);
    check_val("ifu_rdata_o", ifu_rdata_o, ref_read(addr));
    if (after_ls)
    begin
      check_val("ls_done_before_fetch", ls_done, 1);
    end
    @(posedge clk);
    ifu_arvalid <= 1'b0;
  endtask

  task automatic issue_store(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    @(posedge clk);
    lsu_awaddr  <= addr;
    lsu_wdata   <= data;
    lsu_wstrb   <= strb;
    lsu_awvalid <= 1'b1;
    do
    begin
      @(negedge clk);
      if (awvalid)
      begin
        check_val("axi_awaddr_o", awaddr, addr);
        check_val("axi_awsize_o", awsize, size_of(strb));
      end
    end
    while (!lsu_wready_o);
    update_mirror(addr, data, strb);
    ls_done = 1'b1;
    @(posedge clk);
    lsu_awvalid <= 1'b0;
  endtask

  task automatic load_and_compare(input logic [31:0] addr, input logic [3:0] strb);
    @(posedge clk);
    lsu_araddr  <= addr;
    lsu_rstrb   <= strb;
    lsu_arvalid <= 1'b1;
    do
    begin
      @(negedge clk);
      if (arvalid)
      begin
        check_val("axi_araddr_o", araddr, addr);
        check_val("axi_arsize_o", arsize, size_of(strb));
      end
    end
    while (!lsu_rvalid_o);
    check_val("lsu_rdata_o", lsu_rdata_o, ref_read(addr));
    ls_done = 1'b1;
    @(posedge clk);
    lsu_arvalid <= 1'b0;
  endtask

  // data is the count held in the cycle before rvalid
  task automatic timer_read(input logic [31:0] addr);
    logic [63:0] prev;
    integer waited;
    waited = 0;
    @(posedge clk);
    lsu_araddr  <= addr;
    lsu_rstrb   <= 4'hf;
    lsu_arvalid <= 1'b1;
    prev = cyc_since_rst;
    do
    begin
      @(negedge clk);
      waited = waited + 1;
      if (!lsu_rvalid_o)
      begin
        prev = cyc_since_rst;
      end
    end
    while (!lsu_rvalid_o);
    check_val("timer_latency", waited, 3); // grant plus 2 cycles
    if (addr == bus_pkg::RTC_ADDR_UP)
    begin
      check_val("lsu_rdata_o", lsu_rdata_o, prev[63:32]);
    end
    else
    begin
      check_val("lsu_rdata_o", lsu_rdata_o, prev[31:0]);
    end
    @(posedge clk);
    lsu_arvalid <= 1'b0;
  endtask

  // single beats, INCR, id 0 on every address and data beat
  always @(negedge clk)
  begin
    if (!rst && arvalid)
    begin
      check_val("axi_arlen_o", arlen, 0);
      check_val("axi_arburst_o", arburst, BURST_INCR);
      check_val("axi_arid_o", arid, 0);
    end
    if (!rst && awvalid)
    begin
      check_val("axi_awlen_o", awlen, 0);
      check_val("axi_awburst_o", awburst, BURST_INCR);
      check_val("axi_awid_o", awid, 0);
    end
    if (!rst && wvalid)
    begin
      check_val("axi_wlast_o", wlast, 1);
    end
  end

  always @(posedge clk)
  begin
    if (rst)
    begin
      cyc_since_rst <= '0;
    end
    else
    begin
      cyc_since_rst <= cyc_since_rst + 64'd1;
    end
    cyc <= cyc + 1;
    if (u_dut.u_assert.fail_cnt != 0)
    begin
      $display("Error: an AXI protocol assertion failed, run stopped");
      $display("Simulation failed");
      $fatal(1);
    end
    else if (cyc >= LIMIT)
    begin
      $display("Error: no DUT response within %0d cycles, run stopped", LIMIT);
      $display("Simulation failed");
      $fatal(1);
    end
  end

  initial
  begin
    logic [31:0] rnd;
    logic [3:0]  strb;
    clk = 1'b0;
    rst = 1'b1;
    cyc = 0;
    seed = 16575;
    err_cnt = 0;
    ls_done = 1'b0;
    ifu_araddr = '0;
    ifu_arvalid = 1'b0;
    lsu_araddr = '0;
    lsu_arvalid = 1'b0;
    lsu_rstrb = '0;
    lsu_awaddr = '0;
    lsu_awvalid = 1'b0;
    lsu_wdata = '0;
    lsu_wstrb = '0;
    for (int i = 0; i < 4096; i++)
    begin
      ref_mem[i] = 8'(i ^ (i >> 5) ^ 8'h5a);
    end
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < N_FETCH; i++)
    begin
      rnd = $random(seed);
      fetch_and_compare(32'h8000_0000 | (rnd & 32'h0000_0ffc), 1'b0);
    end

    // byte, half, word at each offset of both lanes
    for (int i = 0; i < N_STORE; i++)
    begin
      strb = (i < 8) ? 4'h1 : (i < 16) ? 4'h3 : 4'hf;
      rnd = $random(seed);
      st_addr[i] = 32'h8000_0000 | (rnd & 32'h0000_0ff0) | 32'(i % 8);
      st_strb[i] = strb;
      rnd = $random(seed);
      issue_store(st_addr[i], rnd, strb);
    end
    for (int i = 0; i < N_STORE; i++)
    begin
      load_and_compare(st_addr[i], st_strb[i]);
    end

    timer_read(bus_pkg::RTC_ADDR);
    timer_read(bus_pkg::RTC_ADDR_UP);
    timer_read(bus_pkg::RTC_ADDR);
    timer_read(bus_pkg::RTC_ADDR_UP);

    for (int i = 0; i < N_PAIR; i++)
    begin
      ls_done = 1'b0;
      rnd = $random(seed);
      fork
        fetch_and_compare(32'h8000_0000 | (rnd & 32'h0000_0ffc), 1'b1);
        if (i % 2 == 0)
        begin
          issue_store(32'h8000_0000 | (rnd & 32'h0000_0ff8) | 32'h4, ~rnd, 4'hf);
        end
        else
        begin
          load_and_compare(32'h8000_0000 | (~rnd & 32'h0000_0ffc), 4'hf);
        end
      join
    end

    repeat (2) @(posedge clk);
    if ((err_cnt == 0) && (u_dut.u_assert.fail_cnt == 0))
    begin
      $display("Simulation completed successfully");
      $finish;
    end
    else
    begin
      $display("Simulation failed");
      $fatal(1);
    end
  end

endmodule

//--- compile.f
logic/bus_pkg.sv
logic/lane_align.sv
logic/clint_timer.sv
logic/bus_arbiter.sv
logic/mem_bus_top.sv
tb/axi_mem_slave.sv
tb/bus_assert.sv
tb/tb_mem_bus.sv

//--- run_sim.sh
#!/bin/sh
# builds and runs tb_mem_bus with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tb_mem_bus \
  -Mdir obj_dir -o sim_tb_mem_bus > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_tb_mem_bus > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Simulation completed successfully" sim.log; then
  exit 0
else
  echo "pass message not found in sim.log"
  exit 1
fi
